//--- common/ntm_root_pkg.sv
// Shared widths and payload structs for the vector integer-root unit
// Import into any module that touches root requests or results

package ntm_root_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Radicand, root, modulus and result
  localparam int data_w = 16;
  // Root degree
  localparam int deg_w = 4;
  // Vector length and element counter
  localparam int len_w = 8;

  ////////////////////
  // Payloads
  ////////////////////

  // One element job, sequencer to scalar engine
  typedef struct packed {
    logic [data_w-1:0] radicand;
    logic [deg_w-1:0]  degree;
    // Zero means no reduction
    logic [data_w-1:0] modulo;
  } root_req_t;

  // Reduced root, scalar engine to sequencer
  typedef struct packed {
    logic [data_w-1:0] value;
  } root_rsp_t;

endpackage

//--- rtl/ntm_scalar_mod.sv
// Restoring shift-subtract remainder stage
// One dividend bit per cycle with mod_done data_w+2 cycles after mod_start.
// A zero divisor returns the dividend on the next cycle

module ntm_scalar_mod
  import ntm_root_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              mod_start,
  input  logic [data_w-1:0] mod_dividend,
  input  logic [data_w-1:0] mod_divisor,
  output logic              mod_done,
  output logic [data_w-1:0] mod_value
);

  typedef logic [$clog2(data_w + 1)-1:0] step_t;

  logic              busy;
  step_t             steps;
  logic [data_w-1:0] rem;
  logic [data_w-1:0] dvd;
  logic [data_w-1:0] dsr;
  // Shifted partial remainder and trial difference
  logic [data_w:0]   trial;
  logic [data_w:0]   diff;

  assign trial = {rem, dvd[data_w-1]};
  assign diff  = trial - {1'b0, dsr};

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      steps    <= '0;
      mod_done <= 1'b0;
    end else begin
      mod_done <= 1'b0;
      if (mod_start) begin
        // Zero divisor bypasses the division
        if (mod_divisor == '0) begin
          mod_done <= 1'b1;
        end else begin
          busy  <= 1'b1;
          steps <= step_t'(data_w);
        end
      end else if (busy) begin
        if (steps != '0) begin
          steps <= steps - 1'b1;
        end else begin
          busy     <= 1'b0;
          mod_done <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (mod_start) begin
      rem       <= '0;
      dvd       <= mod_dividend;
      dsr       <= mod_divisor;
      mod_value <= mod_dividend;
    end else if (busy && steps != '0) begin
      // Borrow set means restore
      rem <= diff[data_w] ? trial[data_w-1:0] : diff[data_w-1:0];
      dvd <= dvd << 1;
    end else if (busy) begin
      mod_value <= rem;
    end
  end

endmodule

//--- ntm_scalar_root/ntm_scalar_power.sv
// Iterative saturating power unit
// Raises pow_base to pow_exp with one multiply per cycle.
// Result saturates to all ones on overflow; pow_done after exp+2 cycles

module ntm_scalar_power
  import ntm_root_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              pow_start,
  input  logic [data_w-1:0] pow_base,
  input  logic [deg_w-1:0]  pow_exp,
  output logic              pow_done,
  output logic [data_w-1:0] pow_value
);

  logic                  busy;
  logic [deg_w-1:0]      remaining;
  // Sticky flag for any lost upper product bit
  logic                  ovf;
  logic [data_w-1:0]     base_q;
  logic [data_w-1:0]     acc;
  logic [2*data_w-1:0]   product;

  // Full width product so overflow is visible
  assign product = {{data_w{1'b0}}, acc} * {{data_w{1'b0}}, base_q};

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      remaining <= '0;
      ovf       <= 1'b0;
      pow_done  <= 1'b0;
    end else begin
      pow_done <= 1'b0;
      if (pow_start) begin
        busy      <= 1'b1;
        remaining <= pow_exp;
        ovf       <= 1'b0;
      end else if (busy) begin
        if (remaining != '0) begin
          remaining <= remaining - 1'b1;
          if (product[2*data_w-1:data_w] != '0) begin
            ovf <= 1'b1;
          end
        end else begin
          busy     <= 1'b0;
          pow_done <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (pow_start) begin
      base_q <= pow_base;
      acc    <= {{(data_w - 1){1'b0}}, 1'b1};
    end else if (busy && remaining != '0) begin
      acc <= product[data_w-1:0];
    end
    // Saturate so the root compare still rejects the candidate
    if (!pow_start && busy && remaining == '0) begin
      pow_value <= ovf ? '1 : acc;
    end
  end

endmodule

//--- ntm_scalar_root/ntm_scalar_root.sv
// Scalar integer-root engine
// Finds floor(radicand ** (1/degree)) bit by bit from the MSB down,
// using the power unit as the trial comparator, then reduces the root
// through the remainder stage. One job in flight until eng_done

module ntm_scalar_root
  import ntm_root_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      eng_start,
  input  root_req_t eng_req,
  output logic      eng_done,
  output root_rsp_t eng_rsp
);

  typedef enum logic [1:0] {
    st_idle,
    st_pow,
    st_mod
  } state_t;

  state_t            state;
  // Partial root and one-hot bit under trial
  logic [data_w-1:0] root;
  logic [data_w-1:0] bit_mask;
  // Candidate power fits under the radicand
  logic              cand_fits;

  // Power unit link
  logic              pow_start;
  logic [data_w-1:0] pow_base;
  logic [deg_w-1:0]  pow_exp;
  logic              pow_done;
  logic [data_w-1:0] pow_value;

  // Remainder stage link
  logic              mod_start;
  logic [data_w-1:0] mod_dividend;
  logic [data_w-1:0] mod_divisor;
  logic              mod_done;
  logic [data_w-1:0] mod_value;

  // Candidate is the partial root with the trial bit set
  assign pow_base     = root | bit_mask;
  assign pow_exp      = eng_req.degree;
  assign mod_dividend = root;
  assign mod_divisor  = eng_req.modulo;

  // All ones above degree 1 is always a saturated power,
  // no integer power of degree 2 or more equals all ones at this width
  assign cand_fits = (pow_value <= eng_req.radicand) &&
                     !(pow_value == '1 && eng_req.degree != deg_w'(1));

  ////////////////////
  // Search control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= st_idle;
      root      <= '0;
      bit_mask  <= '0;
      pow_start <= 1'b0;
      mod_start <= 1'b0;
      eng_done  <= 1'b0;
    end else begin
      pow_start <= 1'b0;
      mod_start <= 1'b0;
      eng_done  <= 1'b0;
      case (state)
        st_idle: begin
          if (eng_start) begin
            root     <= '0;
            bit_mask <= {1'b1, {(data_w - 1){1'b0}}};
            // Degree 0 skips straight to reduction of a zero root
            if (eng_req.degree == '0) begin
              mod_start <= 1'b1;
              state     <= st_mod;
            end else begin
              pow_start <= 1'b1;
              state     <= st_pow;
            end
          end
        end
        st_pow: begin
          if (pow_done) begin
            // Keep the bit if candidate**degree fits under A
            if (cand_fits) begin
              root <= pow_base;
            end
            if (bit_mask[0]) begin
              mod_start <= 1'b1;
              state     <= st_mod;
            end else begin
              bit_mask  <= bit_mask >> 1;
              pow_start <= 1'b1;
            end
          end
        end
        st_mod: begin
          if (mod_done) begin
            eng_done <= 1'b1;
            state    <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Result register
  always_ff @(posedge CLK) begin
    if (state == st_mod && mod_done) begin
      eng_rsp.value <= mod_value;
    end
  end

  ntm_scalar_power power0 (
    .CLK       (CLK),
    .RST       (RST),
    .pow_start (pow_start),
    .pow_base  (pow_base),
    .pow_exp   (pow_exp),
    .pow_done  (pow_done),
    .pow_value (pow_value)
  );

  ntm_scalar_mod mod0 (
    .CLK          (CLK),
    .RST          (RST),
    .mod_start    (mod_start),
    .mod_dividend (mod_dividend),
    .mod_divisor  (mod_divisor),
    .mod_done     (mod_done),
    .mod_value    (mod_value)
  );

endmodule

//--- ntm_vector_root/ntm_vector_root.sv
// Vector sequencer for the integer-root unit
// Samples length and modulus on start, collects A and B per element,
// launches the scalar engine and returns one result strobe per element.
// Ready pulses together with the last result

module ntm_vector_root
  import ntm_root_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  logic [len_w-1:0]  size_in,
  input  logic [data_w-1:0] modulo_in,
  input  logic              data_a_in_enable,
  input  logic [data_w-1:0] data_a_in,
  input  logic              data_b_in_enable,
  input  logic [deg_w-1:0]  data_b_in,
  output logic              data_out_enable,
  output logic [data_w-1:0] data_out,
  output logic              ready,
  output logic              eng_start,
  output root_req_t         eng_req,
  input  logic              eng_done,
  input  root_rsp_t         eng_rsp
);

  ////////////////////
  // State
  ////////////////////

  typedef enum logic [1:0] {
    st_idle,
    st_input,
    st_wait
  } state_t;

  state_t            state;
  // Element index and index of the last element
  logic [len_w-1:0]  elem_cnt;
  logic [len_w-1:0]  last_idx;
  // Operand captured flags
  logic              a_held;
  logic              b_held;
  // Operand and modulus holding registers
  logic [data_w-1:0] a_q;
  logic [deg_w-1:0]  b_q;
  logic [data_w-1:0] mod_q;

  // Request stays stable while the engine works
  assign eng_req.radicand = a_q;
  assign eng_req.degree   = b_q;
  assign eng_req.modulo   = mod_q;

  ////////////////////
  // Controller
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= st_idle;
      elem_cnt        <= '0;
      last_idx        <= '0;
      a_held          <= 1'b0;
      b_held          <= 1'b0;
      eng_start       <= 1'b0;
      data_out_enable <= 1'b0;
      data_out        <= '0;
      ready           <= 1'b0;
    end else begin
      // Pulses by default
      eng_start       <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
      case (state)
        st_idle: begin
          // Operand enables ignored here
          if (start) begin
            elem_cnt <= '0;
            // Zero length runs one element
            last_idx <= (size_in == '0) ? '0 : size_in - 1'b1;
            a_held   <= 1'b0;
            b_held   <= 1'b0;
            state    <= st_input;
          end
        end
        st_input: begin
          if (data_a_in_enable) begin
            a_held <= 1'b1;
          end
          if (data_b_in_enable) begin
            b_held <= 1'b1;
          end
          // Launch one cycle after both are in
          if (a_held && b_held) begin
            eng_start <= 1'b1;
            state     <= st_wait;
          end
        end
        st_wait: begin
          if (eng_done) begin
            data_out        <= eng_rsp.value;
            data_out_enable <= 1'b1;
            a_held          <= 1'b0;
            b_held          <= 1'b0;
            if (elem_cnt == last_idx) begin
              ready <= 1'b1;
              state <= st_idle;
            end else begin
              elem_cnt <= elem_cnt + 1'b1;
              state    <= st_input;
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  ////////////////////
  // Operand capture
  ////////////////////

  always_ff @(posedge CLK) begin
    if (state == st_idle && start) begin
      mod_q <= modulo_in;
    end
    // Repeated enable overwrites until the engine is launched
    if (state == st_input && !(a_held && b_held)) begin
      if (data_a_in_enable) begin
        a_q <= data_a_in;
      end
      if (data_b_in_enable) begin
        b_q <= data_b_in;
      end
    end
  end

endmodule

//--- rtl/ntm_root_top.sv
// Top level of the vector integer-root unit
// Connects the element sequencer to the scalar root engine

module ntm_root_top
  import ntm_root_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  logic [len_w-1:0]  size_in,
  input  logic [data_w-1:0] modulo_in,
  input  logic              data_a_in_enable,
  input  logic [data_w-1:0] data_a_in,
  input  logic              data_b_in_enable,
  input  logic [deg_w-1:0]  data_b_in,
  output logic              data_out_enable,
  output logic [data_w-1:0] data_out,
  output logic              ready
);

  // Engine job link
  logic      eng_start;
  root_req_t eng_req;
  logic      eng_done;
  root_rsp_t eng_rsp;

  ntm_vector_root vector0 (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .size_in          (size_in),
    .modulo_in        (modulo_in),
    .data_a_in_enable (data_a_in_enable),
    .data_a_in        (data_a_in),
    .data_b_in_enable (data_b_in_enable),
    .data_b_in        (data_b_in),
    .data_out_enable  (data_out_enable),
    .data_out         (data_out),
    .ready            (ready),
    .eng_start        (eng_start),
    .eng_req          (eng_req),
    .eng_done         (eng_done),
    .eng_rsp          (eng_rsp)
  );

  ntm_scalar_root scalar0 (
    .CLK       (CLK),
    .RST       (RST),
    .eng_start (eng_start),
    .eng_req   (eng_req),
    .eng_done  (eng_done),
    .eng_rsp   (eng_rsp)
  );

endmodule

//--- tests/ntm_root_props.sv
// Protocol checks for the vector sequencer
// Bound into every ntm_vector_root

module ntm_root_props (
  input logic CLK,
  input logic RST,
  input logic data_out_enable,
  input logic ready,
  input logic eng_start,
  input logic eng_done
);
  timeunit 1ns;
  timeprecision 1ps;

  // Engine job launched and not yet done
  logic job_open;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      job_open <= 1'b0;
    end else if (eng_start) begin
      job_open <= 1'b1;
    end else if (eng_done) begin
      job_open <= 1'b0;
    end
  end

  // Ready only with a result
  ready_with_result: assert property (@(posedge CLK) disable iff (RST)
    ready |-> data_out_enable)
    else $error("ready raised without a result strobe");

  single_launch: assert property (@(posedge CLK) disable iff (RST)
    eng_start |-> !job_open)
    else $error("engine launched again before it finished");

  strobe_one_cycle: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |=> !data_out_enable)
    else $error("result strobe longer than one cycle");

  // Control outputs held low in reset
  quiet_in_reset: assert property (@(posedge CLK)
    RST |-> (!data_out_enable && !ready && !eng_start))
    else $error("control output active during reset");

endmodule

bind ntm_vector_root ntm_root_props props0 (
  .CLK             (CLK),
  .RST             (RST),
  .data_out_enable (data_out_enable),
  .ready           (ready),
  .eng_start       (eng_start),
  .eng_done        (eng_done)
);

//--- tests/ntm_root_tb.sv
// Directed testbench for the vector integer-root unit
// Drives ntm_root_top through whole vectors and checks every result strobe
// against a floor-root model. Stops at the first mismatch

module ntm_root_tb
  import ntm_root_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  // Cycles allowed for one element result
  localparam int result_timeout = 2000;

  logic              CLK;
  logic              RST;
  logic              start;
  logic [len_w-1:0]  size_in;
  logic [data_w-1:0] modulo_in;
  logic              data_a_in_enable;
  logic [data_w-1:0] data_a_in;
  logic              data_b_in_enable;
  logic [deg_w-1:0]  data_b_in;
  logic              data_out_enable;
  logic [data_w-1:0] data_out;
  logic              ready;

  // Pending vector, one entry per element
  logic [data_w-1:0] vec_a [$];
  logic [deg_w-1:0]  vec_b [$];
  // 0 A first with a stale A, 1 B first, 2 same cycle
  int                vec_order [$];

  ntm_root_top dut0 (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .size_in          (size_in),
    .modulo_in        (modulo_in),
    .data_a_in_enable (data_a_in_enable),
    .data_a_in        (data_a_in),
    .data_b_in_enable (data_b_in_enable),
    .data_b_in        (data_b_in),
    .data_out_enable  (data_out_enable),
    .data_out         (data_out),
    .ready            (ready)
  );

  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  ////////////////////
  // Reference model
  ////////////////////

  // True when base**exp stays at or below lim
  function automatic bit power_fits(input longint base, input int exp, input longint lim);
    longint p;
    p = 1;
    for (int i = 0; i < exp; i++) begin
      p = p * base;
      if (p > lim) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Floor of the b-th root of a, then mod m unless m is zero
  function automatic logic [data_w-1:0] expect_root(input logic [data_w-1:0] a,
                                                     input logic [deg_w-1:0] b,
                                                     input logic [data_w-1:0] m);
    longint r;
    r = 0;
    if (b != '0) begin
      while (power_fits(r + 64'd1, int'(b), longint'(a))) begin
        r = r + 64'd1;
      end
    end
    if (m != '0) begin
      r = r % longint'(m);
    end
    return data_w'(r);
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  ////////////////////
  // Helpers
  ////////////////////

  task automatic fail_with(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "%s", what);
  endtask

  task automatic expect_no_strobe();
    assert (!data_out_enable && !ready)
      else fail_with("result strobe or ready seen outside of an element");
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge CLK);
      expect_no_strobe();
    end
  endtask

  task automatic clear_vector();
    vec_a.delete();
    vec_b.delete();
    vec_order.delete();
  endtask

  task automatic add_element(input logic [data_w-1:0] a, input logic [deg_w-1:0] b,
                             input int order);
    vec_a.push_back(a);
    vec_b.push_back(b);
    vec_order.push_back(order);
  endtask

  task automatic start_vector(input logic [len_w-1:0] len, input logic [data_w-1:0] m);
    @(negedge CLK);
    start     = 1'b1;
    size_in   = len;
    modulo_in = m;
    @(negedge CLK);
    start     = 1'b0;
    // Only the start cycle may count
    size_in   = len_w'($urandom);
    modulo_in = data_w'($urandom);
  endtask

  task automatic feed_operands(input logic [data_w-1:0] a, input logic [deg_w-1:0] b,
                               input int order);
    @(negedge CLK);
    expect_no_strobe();
    if (order == 0) begin
      // Stale A, then the real one overwrites it
      data_a_in_enable = 1'b1;
      data_a_in        = ~a;
      @(negedge CLK);
      data_a_in        = a;
      @(negedge CLK);
      data_a_in_enable = 1'b0;
      data_b_in_enable = 1'b1;
      data_b_in        = b;
    end else if (order == 1) begin
      data_b_in_enable = 1'b1;
      data_b_in        = b;
      @(negedge CLK);
      data_b_in_enable = 1'b0;
      data_a_in_enable = 1'b1;
      data_a_in        = a;
    end else begin
      data_a_in_enable = 1'b1;
      data_a_in        = a;
      data_b_in_enable = 1'b1;
      data_b_in        = b;
    end
    @(negedge CLK);
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
  endtask

  // Waits for one result strobe and optionally pokes junk enables meanwhile
  task automatic wait_result(input logic [data_w-1:0] want, input bit last, input bit poke,
                             input int idx);
    int cycles;
    cycles = 0;
    while (!data_out_enable && cycles < result_timeout) begin
      @(negedge CLK);
      cycles++;
      if (poke && !data_out_enable) begin
        data_a_in_enable = 1'b1;
        data_a_in        = data_w'($urandom);
        data_b_in_enable = 1'b1;
        data_b_in        = deg_w'($urandom);
      end
    end
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
    assert (data_out_enable)
      else fail_with($sformatf("No result strobe for element %0d before the timeout", idx));
    assert (data_out == want)
      else fail_with($sformatf("** Error: data_out = 0x%h, expected 0x%h at element %0d",
                               data_out, want, idx));
    assert (ready == last)
      else fail_with($sformatf("** Error: ready = 0x%h, expected 0x%h at element %0d",
                               ready, last, idx));
  endtask

  task automatic run_vector(input logic [len_w-1:0] len, input logic [data_w-1:0] m,
                            input bit poke);
    int n;
    n = (len == '0) ? 1 : int'(len);
    assert (vec_a.size() == n)
      else fail_with("Vector setup does not match its length");
    start_vector(len, m);
    for (int k = 0; k < n; k++) begin
      feed_operands(vec_a[k], vec_b[k], vec_order[k]);
      wait_result(expect_root(vec_a[k], vec_b[k], m), k == n - 1, poke, k);
    end
    // Nothing more may follow the last element
    expect_quiet(20);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic square_root_vectors();
    logic [data_w-1:0] picks [11];
    picks = '{16'h0000, 16'h0001, 16'h0003, 16'h0004, 16'h0005,
              16'h0090, 16'h0091, 16'hfe00, 16'hfe01, 16'hfffe, 16'hffff};
    foreach (picks[i]) begin
      clear_vector();
      add_element(picks[i], 4'd2, i % 3);
      run_vector(8'd1, 16'd0, 1'b0);
    end
  endtask

  task automatic higher_degree_vectors();
    logic [deg_w-1:0] degs [4];
    degs = '{4'd1, 4'd3, 4'd7, 4'd15};
    foreach (degs[i]) begin
      clear_vector();
      repeat (4) begin
        add_element(data_w'(rand_range(1, 16'hffff)), degs[i], rand_range(0, 2));
      end
      run_vector(8'd4, 16'd0, 1'b0);
    end
  endtask

  task automatic modulo_vectors();
    logic [data_w-1:0] mods [4];
    // Last modulus is above any square root of 16 bits
    mods = '{16'd1, 16'd3, 16'd10, 16'h0100};
    foreach (mods[i]) begin
      clear_vector();
      repeat (3) begin
        add_element(data_w'(rand_range(0, 16'hffff)), deg_w'(rand_range(2, 3)),
                    rand_range(0, 2));
      end
      run_vector(8'd3, mods[i], 1'b0);
    end
  endtask

  task automatic operand_order_vector();
    int n;
    n = rand_range(1, 12);
    clear_vector();
    for (int k = 0; k < n; k++) begin
      add_element(data_w'(rand_range(0, 16'hffff)), deg_w'(rand_range(1, 15)), k % 3);
    end
    run_vector(len_w'(n), data_w'(rand_range(0, 40)), 1'b0);
  endtask

  task automatic edge_rule_vectors();
    // Degree 0
    clear_vector();
    add_element(16'hbeef, 4'd0, 2);
    add_element(16'h0001, 4'd0, 1);
    run_vector(8'd2, 16'd0, 1'b0);
    // Zero length means one element
    clear_vector();
    add_element(16'h2710, 4'd2, 0);
    run_vector(8'd0, 16'd7, 1'b0);
    // Idle enables
    repeat (3) begin
      @(negedge CLK);
      data_a_in_enable = 1'b1;
      data_a_in        = data_w'($urandom);
      data_b_in_enable = 1'b1;
      data_b_in        = deg_w'($urandom);
    end
    @(negedge CLK);
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
    expect_quiet(5);
    // Busy enables
    clear_vector();
    add_element(16'h3039, 4'd2, 1);
    add_element(16'hfffe, 4'd5, 0);
    add_element(16'h0040, 4'd3, 2);
    run_vector(8'd3, 16'd0, 1'b1);
  endtask

  task automatic reset_during_vector();
    clear_vector();
    add_element(16'hc350, 4'd3, 2);
    add_element(16'h0400, 4'd2, 0);
    start_vector(8'd2, 16'd0);
    feed_operands(vec_a[0], vec_b[0], vec_order[0]);
    // Engine still deep in its search here
    repeat (30) @(negedge CLK);
    RST = 1'b1;
    repeat (3) begin
      @(negedge CLK);
      assert (!data_out_enable && !ready)
        else fail_with("Result strobe or ready active while reset is held");
      assert (data_out == '0)
        else fail_with($sformatf("** Error: data_out = 0x%h, expected 0x%h in reset",
                                 data_out, data_w'(0)));
    end
    RST = 1'b0;
    expect_quiet(3);
    // Fresh vector after the abort
    clear_vector();
    add_element(16'h0400, 4'd2, 0);
    add_element(16'h1b39, 4'd3, 1);
    add_element(16'hfffe, 4'd4, 2);
    run_vector(8'd3, 16'd5, 1'b0);
  endtask

  initial begin
    int unsigned seed;
    seed = 32'h64280c3d;
    void'($urandom(seed));
    RST              = 1'b1;
    start            = 1'b0;
    size_in          = '0;
    modulo_in        = '0;
    data_a_in_enable = 1'b0;
    data_a_in        = '0;
    data_b_in_enable = 1'b0;
    data_b_in        = '0;
    repeat (5) @(negedge CLK);
    RST = 1'b0;
    square_root_vectors();
    higher_degree_vectors();
    modulo_vectors();
    operand_order_vector();
    edge_rule_vectors();
    reset_during_vector();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- ntm_root_top.f
common/ntm_root_pkg.sv
rtl/ntm_scalar_mod.sv
ntm_scalar_root/ntm_scalar_power.sv
ntm_scalar_root/ntm_scalar_root.sv
ntm_vector_root/ntm_vector_root.sv
rtl/ntm_root_top.sv
tests/ntm_root_props.sv
tests/ntm_root_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vector integer-root testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f ntm_root_top.f --top-module ntm_root_tb -Mdir obj_dir

out=$(./obj_dir/Vntm_root_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1
